/* verilog/fp_add_pkg.sv */
`default_nettype none

package fp_add_pkg;

    localparam int FP_EXP_BIAS = 127;
    localparam int FP_EXP_MIN = -126;    // Also the exponent given to subnormals
    localparam int FP_EXP_MAX = 127;

    localparam logic [31:0] FP_QNAN = 32'h7fc0_0000;

    // Field view of a binary32 word
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } fp32_fields_t;

    // The same word as raw bits or as decoded fields
    typedef union packed {
        logic [31:0]  bits;
        fp32_fields_t f;
    } fp32_word_u;

    // One operand after unpacking
    // The mantissa holds the hidden bit, 23 fraction bits and guard, round and sticky
    typedef struct packed {
        logic               sign;
        logic signed [9:0]  exp;
        logic [26:0]        mant;
        logic               is_zero;
        logic               is_inf;
        logic               is_nan;
    } fp_unpacked_t;

    typedef struct packed {
        fp_unpacked_t a;
        fp_unpacked_t b;
    } fp_operand_pair_t;

endpackage

`default_nettype wire

/* verilog/fp_operand_capture.sv */
`default_nettype none

module fp_operand_capture (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [31:0]                  i_a,
    input  wire  [31:0]                  i_b,
    input  wire                          i_stb_a,
    input  wire                          i_stb_b,
    output logic                         o_in_ack,
    input  wire                          i_take,
    output fp_add_pkg::fp_operand_pair_t o_pair,
    output logic                         o_pair_valid
);
    import fp_add_pkg::*;

    localparam logic [1:0] S_WAIT_A = 2'd0;
    localparam logic [1:0] S_WAIT_B = 2'd1;
    localparam logic [1:0] S_FULL = 2'd2;

    logic [1:0] state;
    logic       accept_a;
    logic       accept_b;
    fp32_word_u a_word;
    fp32_word_u b_word;

    function automatic fp_unpacked_t unpack(input fp32_word_u w);
        fp_unpacked_t u;
        logic         exp_zero;
        logic         exp_ones;
        logic         frac_zero;
        exp_zero = (w.f.exp == 8'd0);
        exp_ones = (w.f.exp == 8'hff);
        frac_zero = (w.f.frac == 23'd0);
        u.sign = w.f.sign;
        if (exp_zero)
            u.exp = 10'(FP_EXP_MIN);
        else
            u.exp = 10'($signed({2'b00, w.f.exp}) - FP_EXP_BIAS);
        u.mant = {~exp_zero, w.f.frac, 3'b000};   // No hidden bit for subnormals
        u.is_zero = exp_zero & frac_zero;
        u.is_inf = exp_ones & frac_zero;
        u.is_nan = exp_ones & ~frac_zero;
        return u;
    endfunction

    assign accept_a = (state == S_WAIT_A) && o_in_ack && i_stb_a;
    assign accept_b = (state == S_WAIT_B) && o_in_ack && i_stb_b;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= S_WAIT_A;
            o_in_ack <= 1'b0;
            o_pair_valid <= 1'b0;
        end
        else
        begin
            case (state)
                S_WAIT_A:
                begin
                    o_in_ack <= ~accept_a;   // Drops for a cycle after each operand
                    if (accept_a)
                        state <= S_WAIT_B;
                end
                S_WAIT_B:
                begin
                    o_in_ack <= ~accept_b;
                    if (accept_b)
                    begin
                        o_pair_valid <= 1'b1;
                        state <= S_FULL;
                    end
                end
                S_FULL:
                begin
                    if (i_take)
                    begin
                        o_pair_valid <= 1'b0;
                        state <= S_WAIT_A;
                    end
                end
                default:
                    state <= S_WAIT_A;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept_a)
            a_word.bits <= i_a;
        if (accept_b)
            b_word.bits <= i_b;
    end

    // Both words stay put until the core takes the pair
    assign o_pair = {unpack(a_word), unpack(b_word)};

endmodule

`default_nettype wire

/* verilog/fp_add_core.sv */
`default_nettype none

module fp_add_core (
    input  wire                          clk,
    input  wire                          rst,
    input  wire fp_add_pkg::fp_operand_pair_t i_pair,
    input  wire                          i_pair_valid,
    output logic                         o_take,
    input  wire                          i_free,
    output logic [31:0]                  o_result,
    output logic                         o_done
);
    import fp_add_pkg::*;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_SPECIAL = 3'd1;
    localparam logic [2:0] S_ALIGN = 3'd2;
    localparam logic [2:0] S_ADD = 3'd3;
    localparam logic [2:0] S_NORM = 3'd4;
    localparam logic [2:0] S_ROUND = 3'd5;
    localparam logic [2:0] S_PACK = 3'd6;
    localparam logic [2:0] S_DONE = 3'd7;

    logic [2:0]        state;
    fp_unpacked_t      op_a;
    fp_unpacked_t      op_b;
    logic signed [9:0] exp_diff;
    logic              z_s;
    logic signed [9:0] z_e;
    logic [27:0]       sum;           // Carry bit on top, guard/round/sticky at the bottom
    logic [24:0]       z_m;
    logic              round_up;
    logic signed [9:0] exp_final;
    logic [22:0]       frac_final;
    logic [31:0]       packed_word;
    logic [31:0]       z;

    assign o_take = (state == S_IDLE) && i_pair_valid;
    assign o_done = (state == S_DONE) && i_free;
    assign o_result = z;

    assign exp_diff = op_a.exp - op_b.exp;
    assign round_up = sum[2] & (sum[1] | sum[0] | sum[3]);   // Ties go to the even mantissa

    always_comb
    begin
        exp_final = z_m[24] ? z_e + 10'sd1 : z_e;
        frac_final = z_m[24] ? z_m[23:1] : z_m[22:0];
        if (exp_final > FP_EXP_MAX)
            packed_word = {z_s, 8'hff, 23'd0};
        else if (!(z_m[24] | z_m[23]))
            packed_word = {z_s & (z_m != 25'd0), 8'd0, frac_final};   // Cancellation is +0
        else
            packed_word = {z_s, 8'(exp_final + FP_EXP_BIAS), frac_final};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                    if (o_take)
                        state <= S_SPECIAL;
                S_SPECIAL:
                    if (op_a.is_nan || op_b.is_nan || op_a.is_inf || op_b.is_inf ||
                        (op_a.is_zero && op_b.is_zero))
                        state <= S_DONE;
                    else
                        state <= S_ALIGN;
                S_ALIGN:
                    if (exp_diff == 10'sd0)
                        state <= S_ADD;
                S_ADD:
                    state <= S_NORM;
                S_NORM:
                    if (!sum[27] && (sum[26] || z_e == FP_EXP_MIN || sum == 28'd0))
                        state <= S_ROUND;
                S_ROUND:
                    state <= S_PACK;
                S_PACK:
                    state <= S_DONE;
                S_DONE:
                    if (i_free)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
                if (o_take)
                begin
                    op_a <= i_pair.a;
                    op_b <= i_pair.b;
                end
            S_SPECIAL:
                if (op_a.is_nan || op_b.is_nan ||
                    (op_a.is_inf && op_b.is_inf && op_a.sign != op_b.sign))
                    z <= FP_QNAN;
                else if (op_a.is_inf)
                    z <= {op_a.sign, 8'hff, 23'd0};
                else if (op_b.is_inf)
                    z <= {op_b.sign, 8'hff, 23'd0};
                else
                    z <= {op_a.sign & op_b.sign, 31'd0};   // Only -0 plus -0 stays negative
            S_ALIGN:
                // Shift the smaller operand right, folding lost bits into sticky
                if (exp_diff > 10'sd26)
                begin
                    op_b.mant <= {26'd0, |op_b.mant};
                    op_b.exp <= op_a.exp;
                end
                else if (exp_diff > 10'sd0)
                begin
                    op_b.mant <= {1'b0, op_b.mant[26:2], op_b.mant[1] | op_b.mant[0]};
                    op_b.exp <= op_b.exp + 10'sd1;
                end
                else if (exp_diff < -10'sd26)
                begin
                    op_a.mant <= {26'd0, |op_a.mant};
                    op_a.exp <= op_b.exp;
                end
                else if (exp_diff < 10'sd0)
                begin
                    op_a.mant <= {1'b0, op_a.mant[26:2], op_a.mant[1] | op_a.mant[0]};
                    op_a.exp <= op_a.exp + 10'sd1;
                end
            S_ADD:
            begin
                z_e <= op_a.exp;
                if (op_a.sign == op_b.sign)
                begin
                    sum <= {1'b0, op_a.mant} + {1'b0, op_b.mant};
                    z_s <= op_a.sign;
                end
                else if (op_a.mant >= op_b.mant)
                begin
                    sum <= {1'b0, op_a.mant} - {1'b0, op_b.mant};
                    z_s <= op_a.sign;
                end
                else
                begin
                    sum <= {1'b0, op_b.mant} - {1'b0, op_a.mant};
                    z_s <= op_b.sign;
                end
            end
            S_NORM:
                if (sum[27])
                begin
                    sum <= {1'b0, sum[27:2], sum[1] | sum[0]};
                    z_e <= z_e + 10'sd1;
                end
                else if (!sum[26] && z_e > FP_EXP_MIN && sum != 28'd0)
                begin
                    sum <= {sum[26:0], 1'b0};   // Stops at the subnormal exponent
                    z_e <= z_e - 10'sd1;
                end
            S_ROUND:
                z_m <= {1'b0, sum[26:3]} + {24'd0, round_up};
            S_PACK:
                z <= packed_word;
            default:
                z <= z;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/fp_result_port.sv */
`default_nettype none

module fp_result_port (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] i_result,
    input  wire         i_done,
    input  wire         i_z_ack,
    output logic [31:0] o_z,
    output logic        o_z_stb,
    output logic        o_free
);

    logic full;

    always_ff @(posedge clk)
    begin
        if (rst)
            full <= 1'b0;
        else if (i_done)
            full <= 1'b1;   // A new load wins over an acknowledge on the same edge
        else if (i_z_ack)
            full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (i_done)
            o_z <= i_result;
    end

    assign o_z_stb = full;

    // Slot is free now or empties on this edge
    assign o_free = ~full | i_z_ack;

endmodule

`default_nettype wire

/* verilog/fp_adder_top.sv */
`default_nettype none

module fp_adder_top (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] i_a,
    input  wire  [31:0] i_b,
    input  wire         i_stb_a,
    input  wire         i_stb_b,
    input  wire         i_z_ack,
    output logic        o_in_ack,
    output logic [31:0] o_z,
    output logic        o_z_stb
);
    import fp_add_pkg::*;

    fp_operand_pair_t pair;
    logic             pair_valid;
    logic             take;
    logic [31:0]      result;
    logic             done;
    logic             free;

    fp_operand_capture capture_i (
        .clk          (clk),
        .rst          (rst),
        .i_a          (i_a),
        .i_b          (i_b),
        .i_stb_a      (i_stb_a),
        .i_stb_b      (i_stb_b),
        .o_in_ack     (o_in_ack),
        .i_take       (take),
        .o_pair       (pair),
        .o_pair_valid (pair_valid)
    );

    fp_add_core core_i (
        .clk          (clk),
        .rst          (rst),
        .i_pair       (pair),
        .i_pair_valid (pair_valid),
        .o_take       (take),
        .i_free       (free),
        .o_result     (result),
        .o_done       (done)
    );

    fp_result_port result_i (
        .clk      (clk),
        .rst      (rst),
        .i_result (result),
        .i_done   (done),
        .i_z_ack  (i_z_ack),
        .o_z      (o_z),
        .o_z_stb  (o_z_stb),
        .o_free   (free)
    );

endmodule

`default_nettype wire

/* dv/fp_adder_asserts.sv */
`default_nettype none

module fp_adder_asserts (
    input wire        clk,
    input wire        rst,
    input wire        o_in_ack,
    input wire        i_stb_a,
    input wire        i_stb_b,
    input wire        o_z_stb,
    input wire        i_z_ack,
    input wire [31:0] o_z
);

    logic awaiting_b;
    logic accepted;

    // Tracks which operand the capture side expects next
    always_ff @(posedge clk)
    begin
        if (rst)
            awaiting_b <= 1'b0;
        else if (accepted)
            awaiting_b <= ~awaiting_b;
    end

    assign accepted = o_in_ack && (awaiting_b ? i_stb_b : i_stb_a);

    z_stable: assert property (@(posedge clk) disable iff (rst)
        (o_z_stb && !i_z_ack) |=> $stable(o_z))
        else $error("o_z changed while the result was waiting for ack");

    z_stb_held: assert property (@(posedge clk) disable iff (rst)
        (o_z_stb && !i_z_ack) |=> o_z_stb)
        else $error("o_z_stb dropped before ack");

    in_ack_reset: assert property (@(posedge clk)
        rst |=> !o_in_ack)
        else $error("o_in_ack high during or right after reset");

    in_ack_drop: assert property (@(posedge clk) disable iff (rst)
        accepted |=> !o_in_ack)
        else $error("o_in_ack did not fall after an accepted operand");

endmodule

bind fp_adder_top fp_adder_asserts asserts_i (
    .clk      (clk),
    .rst      (rst),
    .o_in_ack (o_in_ack),
    .i_stb_a  (i_stb_a),
    .i_stb_b  (i_stb_b),
    .o_z_stb  (o_z_stb),
    .i_z_ack  (i_z_ack),
    .o_z      (o_z)
);

`default_nettype wire

/* dv/fp_adder_tb.sv */
`default_nettype none

module fp_adder_tb;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] z;
    } vector_t;

    localparam int NUM_VECTORS = 25;
    localparam int NUM_SWAPS = 12;
    localparam int TIMEOUT_CYCLES = 500;
    localparam int QUIET_CYCLES = 100;

    logic        clk;
    logic        rst;
    logic [31:0] i_a;
    logic [31:0] i_b;
    logic        i_stb_a;
    logic        i_stb_b;
    logic        i_z_ack;
    logic        o_in_ack;
    logic [31:0] o_z;
    logic        o_z_stb;

    int unsigned lcg_state = 33;
    vector_t     jobs[$];
    int          ack_delays[$];

    // Operand A, operand B, expected sum
    vector_t vectors [NUM_VECTORS] = '{
        '{32'h3f800000, 32'h3f800000, 32'h40000000},   // Carry out of the mantissa
        '{32'h3f800000, 32'h40000000, 32'h40400000},
        '{32'h3fc00000, 32'hbf000000, 32'h3f800000},
        '{32'h3f800000, 32'hc0400000, 32'hc0000000},   // Larger magnitude sets the sign
        '{32'h3dcccccd, 32'h3e4ccccd, 32'h3e99999a},
        '{32'h3f800001, 32'hbf800000, 32'h34000000},   // 23 left shifts
        '{32'h3f800000, 32'h33800000, 32'h3f800000},   // Tie stays on even
        '{32'h3f800001, 32'h33800000, 32'h3f800002},   // Tie moves up to even
        '{32'h3f800000, 32'h00000001, 32'h3f800000},
        '{32'h7fc00000, 32'h3f800000, 32'h7fc00000},
        '{32'h3f800000, 32'hff800001, 32'h7fc00000},
        '{32'h7f800000, 32'h3f800000, 32'h7f800000},
        '{32'hff800000, 32'h42280000, 32'hff800000},
        '{32'h7f800000, 32'hff800000, 32'h7fc00000},
        '{32'h7f800000, 32'h7f800000, 32'h7f800000},
        '{32'h00000000, 32'h80000000, 32'h00000000},
        '{32'h80000000, 32'h80000000, 32'h80000000},
        '{32'h80000000, 32'h40400000, 32'h40400000},
        '{32'h3e99999a, 32'hbe99999a, 32'h00000000},
        '{32'h00000001, 32'h00000001, 32'h00000002},
        '{32'h00400000, 32'h00400000, 32'h00800000},   // Subnormals reach the normal range
        '{32'h00800001, 32'h80800000, 32'h00000001},
        '{32'h00c00000, 32'h80800000, 32'h00400000},
        '{32'h7f7fffff, 32'h7f7fffff, 32'h7f800000},
        '{32'hff7fffff, 32'hff7fffff, 32'hff800000}
    };

    fp_adder_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .i_a      (i_a),
        .i_b      (i_b),
        .i_stb_a  (i_stb_a),
        .i_stb_b  (i_stb_b),
        .i_z_ack  (i_z_ack),
        .o_in_ack (o_in_ack),
        .o_z      (o_z),
        .o_z_stb  (o_z_stb)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %s expected %h got %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic build_jobs();
        vector_t swapped;
        int      idx;
        foreach (vectors[i])
            jobs.push_back(vectors[i]);
        for (int n = 0; n < NUM_SWAPS; n++)
        begin
            idx = int'(lcg_next() % NUM_VECTORS);
            swapped.a = vectors[idx].b;   // Same expected word with the operands exchanged
            swapped.b = vectors[idx].a;
            swapped.z = vectors[idx].z;
            jobs.push_back(swapped);
        end
        foreach (jobs[i])
            ack_delays.push_back(int'(lcg_next() % 16));
    endtask

    // Called on a falling edge, returns on the falling edge after the handshake
    task automatic offer_word(input logic is_b, input logic [31:0] word);
        int cycles;
        cycles = 0;
        if (is_b)
        begin
            i_b = word;
            i_stb_b = 1'b1;
        end
        else
        begin
            i_a = word;
            i_stb_a = 1'b1;
        end
        while (!o_in_ack)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                $display("Timeout: o_in_ack stayed low while an operand was offered");
                stop_with_failure();
            end
        end
        @(negedge clk);
        i_stb_a = 1'b0;
        i_stb_b = 1'b0;
    endtask

    task automatic collect_result(input logic [31:0] expected, input int delay);
        int cycles;
        cycles = 0;
        while (!o_z_stb)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                $display("Timeout: no result strobe from the adder");
                stop_with_failure();
            end
        end
        repeat (delay) @(negedge clk);   // Back-pressure on the result port
        check_value("o_z", o_z, expected);
        i_z_ack = 1'b1;
        @(negedge clk);
        i_z_ack = 1'b0;
    endtask

    // A duplicated result would show up as a strobe after the last expected one
    task automatic expect_no_extra_result();
        for (int n = 0; n < QUIET_CYCLES; n++)
        begin
            if (o_z_stb)
            begin
                $display("The adder produced a result that no operand pair asked for");
                stop_with_failure();
            end
            @(negedge clk);
        end
    endtask

    task automatic send_all_operands();
        foreach (jobs[i])
        begin
            offer_word(1'b0, jobs[i].a);
            offer_word(1'b1, jobs[i].b);
        end
    endtask

    task automatic receive_all_results();
        foreach (jobs[i])
            collect_result(jobs[i].z, ack_delays[i]);
    endtask

    initial
    begin
        rst = 1'b1;
        i_a = 32'd0;
        i_b = 32'd0;
        i_stb_a = 1'b0;
        i_stb_b = 1'b0;
        i_z_ack = 1'b0;
        build_jobs();
        repeat (5) @(negedge clk);
        check_value("o_in_ack", {31'd0, o_in_ack}, 32'd0);
        check_value("o_z_stb", {31'd0, o_z_stb}, 32'd0);
        rst = 1'b0;
        @(negedge clk);
        check_value("o_in_ack", {31'd0, o_in_ack}, 32'd1);   // Up one cycle after reset
        fork
            send_all_operands();
            receive_all_results();
        join
        expect_no_extra_result();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
verilog/fp_add_pkg.sv
verilog/fp_operand_capture.sv
verilog/fp_add_core.sv
verilog/fp_result_port.sv
verilog/fp_adder_top.sv
dv/fp_adder_asserts.sv
dv/fp_adder_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= fp_adder_tb
RTL_TOP    ?= fp_adder_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

RTL_FILES ?= verilog/fp_add_pkg.sv \
             verilog/fp_operand_capture.sv \
             verilog/fp_add_core.sv \
             verilog/fp_result_port.sv \
             verilog/fp_adder_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)
